/* Makefile */
TOP = tb_csr_file

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module csr_file

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "sim passed" sim.log || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* csr_consts.svh */
// CSR file constants
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

////////////////////////////////////////////////////////////
// Widths
`define CSR_XLEN            32
`define CSR_IDX_W           12

////////////////////////////////////////////////////////////
// Machine-mode CSR indices
`define CSR_ADDR_MSTATUS     12'h300
`define CSR_ADDR_MISA        12'h301
`define CSR_ADDR_MIE         12'h304
`define CSR_ADDR_MTVEC       12'h305
`define CSR_ADDR_MSCRATCH    12'h340
`define CSR_ADDR_MEPC        12'h341
`define CSR_ADDR_MCAUSE      12'h342
`define CSR_ADDR_MIP         12'h344
`define CSR_ADDR_MCYCLE      12'hB00
`define CSR_ADDR_MCYCLEH     12'hB80
`define CSR_ADDR_MINSTRET    12'hB02
`define CSR_ADDR_MINSTRETH   12'hB82
`define CSR_ADDR_COUNTERSTOP 12'hBFF  // Custom index the ISA leaves unused

////////////////////////////////////////////////////////////
// Field positions and masks
`define CSR_BIT_MIE          3   // mstatus
`define CSR_BIT_MPIE         7
`define CSR_BIT_MEIE         11  // mie and mip
`define CSR_BIT_MTIE         7
`define CSR_BIT_MSIE         3
`define CSR_MSTATUS_MPP      32'h0000_1800  // MPP reads as machine mode
`define CSR_MIE_MASK         32'h0000_0888
`define CSR_MCAUSE_MASK      32'h8000_000F  // Interrupt flag and 4-bit code
`define CSR_CNTSTOP_MASK     32'h0000_0007

// RV32 with I, M, A and C
`define CSR_MISA_VAL         32'h4000_1105
`define CSR_MTVEC_RESET      32'h8000_0100

`endif

/* csr_counters.sv */
// Cycle and instret counter bank
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_counters import csr_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  csr_dec_t dec,
  input  logic     instret,
  output csr_rd_t  rd,
  output logic     tm_stop
);

  logic [`CSR_XLEN-1:0] mcycle_r, mcycleh_r;
  logic [`CSR_XLEN-1:0] minstret_r, minstreth_r;
  logic [`CSR_XLEN-1:0] cntstop_r;
  logic [`CSR_XLEN-1:0] rd_val;
  logic                 bank_sel;

  wire wr_mcycle    = dec.wen & (dec.sel == CSR_SEL_MCYCLE);
  wire wr_mcycleh   = dec.wen & (dec.sel == CSR_SEL_MCYCLEH);
  wire wr_minstret  = dec.wen & (dec.sel == CSR_SEL_MINSTRET);
  wire wr_minstreth = dec.wen & (dec.sel == CSR_SEL_MINSTRETH);
  wire wr_cntstop   = dec.wen & (dec.sel == CSR_SEL_COUNTERSTOP);

  wire cy_stop = cntstop_r[0];  // Freeze mcycle
  wire ir_stop = cntstop_r[2];  // Freeze minstret

  // Carry into the high word when the low word is all ones
  wire cy_inc  = ~cy_stop;
  wire cyh_inc = cy_inc & (mcycle_r == '1);
  wire ir_inc  = ~ir_stop & instret;
  wire irh_inc = ir_inc & (minstret_r == '1);

  ////////////////////////////////////////////////////////////
  // A write to a counter word beats its increment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_r    <= '0;
      mcycleh_r   <= '0;
      minstret_r  <= '0;
      minstreth_r <= '0;
      cntstop_r   <= '0;
    end else begin
      if (wr_mcycle)         mcycle_r    <= dec.wdata;
      else if (cy_inc)       mcycle_r    <= mcycle_r + 1'b1;
      if (wr_mcycleh)        mcycleh_r   <= dec.wdata;
      else if (cyh_inc)      mcycleh_r   <= mcycleh_r + 1'b1;
      if (wr_minstret)       minstret_r  <= dec.wdata;
      else if (ir_inc)       minstret_r  <= minstret_r + 1'b1;
      if (wr_minstreth)      minstreth_r <= dec.wdata;
      else if (irh_inc)      minstreth_r <= minstreth_r + 1'b1;
      if (wr_cntstop)
        cntstop_r <= dec.wdata & `CSR_CNTSTOP_MASK;  // Low 3 bits only
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  always_comb begin
    bank_sel = 1'b1;
    rd_val   = '0;
    case (dec.sel)
      CSR_SEL_MCYCLE:      rd_val = mcycle_r;
      CSR_SEL_MCYCLEH:     rd_val = mcycleh_r;
      CSR_SEL_MINSTRET:    rd_val = minstret_r;
      CSR_SEL_MINSTRETH:   rd_val = minstreth_r;
      CSR_SEL_COUNTERSTOP: rd_val = cntstop_r;
      default:             bank_sel = 1'b0;
    endcase
  end

  assign rd.hit  = dec.ren & bank_sel;
  assign rd.data = rd.hit ? rd_val : '0;

  assign tm_stop = cntstop_r[1];  // Timer stop goes out to the timer block

endmodule

/* csr_decode.sv */
// CSR index decoder
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_decode import csr_pkg::*; (
  input  csr_req_t req,
  output csr_dec_t dec,
  output logic     access_ilgl
);

  csr_sel_e sel;    // Raw selection, before legality
  logic     known;  // Index names an implemented register
  logic     ro_wr;  // Write to a read-only register
  logic     legal;

  ////////////////////////////////////////////////////////////
  // Index compared once for both banks
  always_comb begin
    unique case (req.idx)
      `CSR_ADDR_MSTATUS:     sel = CSR_SEL_MSTATUS;
      `CSR_ADDR_MISA:        sel = CSR_SEL_MISA;
      `CSR_ADDR_MIE:         sel = CSR_SEL_MIE;
      `CSR_ADDR_MTVEC:       sel = CSR_SEL_MTVEC;
      `CSR_ADDR_MSCRATCH:    sel = CSR_SEL_MSCRATCH;
      `CSR_ADDR_MEPC:        sel = CSR_SEL_MEPC;
      `CSR_ADDR_MCAUSE:      sel = CSR_SEL_MCAUSE;
      `CSR_ADDR_MIP:         sel = CSR_SEL_MIP;
      `CSR_ADDR_MCYCLE:      sel = CSR_SEL_MCYCLE;
      `CSR_ADDR_MCYCLEH:     sel = CSR_SEL_MCYCLEH;
      `CSR_ADDR_MINSTRET:    sel = CSR_SEL_MINSTRET;
      `CSR_ADDR_MINSTRETH:   sel = CSR_SEL_MINSTRETH;
      `CSR_ADDR_COUNTERSTOP: sel = CSR_SEL_COUNTERSTOP;
      default:               sel = CSR_SEL_NONE;  // Unknown index
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Legality and strobe qualification
  assign known = (sel != CSR_SEL_NONE);
  assign ro_wr = req.wr & (sel == CSR_SEL_MISA);  // misa is the only read-only one
  assign legal = known & ~ro_wr;

  assign access_ilgl = req.ena & ~legal;  // Only flagged on a real access

  // Strobes only toggle for a legal, enabled access
  assign dec.sel   = sel;
  assign dec.wen   = req.ena & req.wr & legal;
  assign dec.ren   = req.ena & req.rd & legal;
  assign dec.wdata = req.wdata;

endmodule

/* csr_file.sv */
// Machine-mode CSR file top
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_file import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_req_t             req,
  input  csr_cmt_t             cmt,
  input  csr_irq_t             irq,
  output logic [`CSR_XLEN-1:0] rdata,
  output logic                 access_ilgl,
  output csr_trap_ctrl_t       ctrl,
  output logic                 tm_stop
);

  csr_dec_t dec;      // Shared decode to both banks
  csr_rd_t  trap_rd;
  csr_rd_t  cnt_rd;

  ////////////////////////////////////////////////////////////
  // Decode, register banks, read combine
  csr_decode u_decode (
    .req         (req),
    .dec         (dec),
    .access_ilgl (access_ilgl)
  );

  csr_trap_regs u_trap_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .dec   (dec),
    .cmt   (cmt),
    .irq   (irq),
    .rd    (trap_rd),
    .ctrl  (ctrl)
  );

  csr_counters u_counters (
    .clk     (clk),
    .rst_n   (rst_n),
    .dec     (dec),
    .instret (cmt.instret),  // Retire pulse from commit
    .rd      (cnt_rd),
    .tm_stop (tm_stop)
  );

  csr_read_mux u_read_mux (
    .dec     (dec),
    .trap_rd (trap_rd),
    .cnt_rd  (cnt_rd),
    .rdata   (rdata)
  );

endmodule

/* csr_golden.txt */
// Columns, all hex: op idx data expected. Ops 0 idle 1 read 2 write 3 trap 4 mret 5 instret 6 irq
// Read: data bit 0 is the expected illegal flag. Write: expected bit 0 is the illegal flag
// Idle with idx bit 8 set checks ctrl: idx bits 4..0 mie/meie/mtie/msie/tm_stop, data mepc, exp mtvec
00000002 00000340 A5A55A5A 00000000
00000001 00000340 00000000 A5A55A5A
00000002 00000305 00002004 00000000
00000001 00000305 00000000 00002004
00000002 00000304 FFFFFFFF 00000000
00000001 00000304 00000000 00000888
00000002 00000BFF FFFFFFFF 00000000
00000001 00000BFF 00000000 00000007
00000000 0000010F 00000000 00002004
00000002 00000300 00000008 00000000
00000001 00000300 00000000 00001808
00000003 00000300 80001235 FFFFFFF7
00000001 00000300 00000000 00001880
00000001 00000341 00000000 80001234
00000001 00000342 00000000 80000007
00000004 00000000 00000000 00000000
00000001 00000300 00000000 00001888
00000006 00000000 00000005 00000000
00000001 00000344 00000000 00000880
00000002 00000B00 12345678 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000001 00000B00 00000000 12345678
00000002 00000BFF 00000001 00000000
00000002 00000B02 FFFFFFFF 00000000
00000002 00000B82 00000000 00000000
00000005 00000000 00000000 00000000
00000005 00000000 00000000 00000000
00000005 00000000 00000000 00000000
00000005 00000000 00000000 00000000
00000005 00000000 00000000 00000000
00000001 00000B02 00000000 00000004
00000001 00000B82 00000000 00000001
00000001 000007C0 00000001 00000000
00000002 00000301 00000000 00000001
00000001 00000301 00000000 40001105
00000000 0000011E 80001234 00002004

/* csr_pkg.sv */
// CSR file shared types
`include "csr_consts.svh"

package csr_pkg;

  // One value per implemented register
  typedef enum logic [4:0] {
    CSR_SEL_NONE,
    CSR_SEL_MSTATUS,
    CSR_SEL_MISA,
    CSR_SEL_MIE,
    CSR_SEL_MTVEC,
    CSR_SEL_MSCRATCH,
    CSR_SEL_MEPC,
    CSR_SEL_MCAUSE,
    CSR_SEL_MIP,
    CSR_SEL_MCYCLE,
    CSR_SEL_MCYCLEH,
    CSR_SEL_MINSTRET,
    CSR_SEL_MINSTRETH,
    CSR_SEL_COUNTERSTOP
  } csr_sel_e;

  // Access from the execute stage
  typedef struct packed {
    logic                    ena;
    logic                    wr;
    logic                    rd;
    logic [`CSR_IDX_W-1:0]   idx;
    logic [`CSR_XLEN-1:0]    wdata;
  } csr_req_t;

  // Commit stage events
  typedef struct packed {
    logic                    trap;
    logic                    mret;
    logic                    epc_ena;
    logic [`CSR_XLEN-1:0]    epc;
    logic                    cause_ena;
    logic [`CSR_XLEN-1:0]    cause;
    logic                    instret;
  } csr_cmt_t;

  typedef struct packed {
    logic ext;
    logic sft;
    logic tmr;
  } csr_irq_t;

  // Decoded access, strobes already qualified
  typedef struct packed {
    csr_sel_e                sel;
    logic                    wen;
    logic                    ren;
    logic [`CSR_XLEN-1:0]    wdata;
  } csr_dec_t;

  typedef struct packed {
    logic                    hit;
    logic [`CSR_XLEN-1:0]    data;
  } csr_rd_t;

  // Trap state seen by the core
  typedef struct packed {
    logic                    status_mie;
    logic                    meie;
    logic                    mtie;
    logic                    msie;
    logic [`CSR_XLEN-1:0]    mepc;
    logic [`CSR_XLEN-1:0]    mtvec;
  } csr_trap_ctrl_t;

endpackage

/* csr_read_mux.sv */
// CSR read data combiner
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_read_mux import csr_pkg::*; (
  input  csr_dec_t             dec,
  input  csr_rd_t              trap_rd,
  input  csr_rd_t              cnt_rd,
  output logic [`CSR_XLEN-1:0] rdata
);

  // misa lives in neither bank
  wire misa_hit = dec.ren & (dec.sel == CSR_SEL_MISA);

  always_comb begin
    if (misa_hit)
      rdata = `CSR_MISA_VAL;
    else if (trap_rd.hit)
      rdata = trap_rd.data;
    else if (cnt_rd.hit)
      rdata = cnt_rd.data;
    else
      rdata = '0;  // Illegal, or no read this cycle
  end

endmodule

/* csr_trap_regs.sv */
// Machine trap register bank
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_trap_regs import csr_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  csr_dec_t       dec,
  input  csr_cmt_t       cmt,
  input  csr_irq_t       irq,
  output csr_rd_t        rd,
  output csr_trap_ctrl_t ctrl
);

  logic                 status_mie;
  logic                 status_mpie;
  logic [`CSR_XLEN-1:0] mie_r;
  logic                 meip, mtip, msip;  // Registered interrupt lines
  logic [`CSR_XLEN-1:0] mepc_r;
  logic [`CSR_XLEN-1:0] mcause_r;
  logic [`CSR_XLEN-1:0] mtvec_r;
  logic [`CSR_XLEN-1:0] mscratch_r;
  logic [`CSR_XLEN-1:0] mstatus_val;
  logic [`CSR_XLEN-1:0] mip_val;
  logic [`CSR_XLEN-1:0] epc_nxt;
  logic [`CSR_XLEN-1:0] rd_val;
  logic                 bank_sel;

  // Write strobes per register
  wire wr_mstatus  = dec.wen & (dec.sel == CSR_SEL_MSTATUS);
  wire wr_mie      = dec.wen & (dec.sel == CSR_SEL_MIE);
  wire wr_mepc     = dec.wen & (dec.sel == CSR_SEL_MEPC);
  wire wr_mcause   = dec.wen & (dec.sel == CSR_SEL_MCAUSE);
  wire wr_mtvec    = dec.wen & (dec.sel == CSR_SEL_MTVEC);
  wire wr_mscratch = dec.wen & (dec.sel == CSR_SEL_MSCRATCH);

  ////////////////////////////////////////////////////////////
  // mstatus MIE and MPIE
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_mie  <= 1'b0;
      status_mpie <= 1'b0;
    end else if (cmt.trap) begin      // Save MIE, then mask interrupts
      status_mpie <= status_mie;
      status_mie  <= 1'b0;
    end else if (cmt.mret) begin      // Restore MIE from MPIE
      status_mie  <= status_mpie;
      status_mpie <= 1'b1;
    end else if (wr_mstatus) begin
      status_mie  <= dec.wdata[`CSR_BIT_MIE];
      status_mpie <= dec.wdata[`CSR_BIT_MPIE];
    end
  end

  always_comb begin
    mstatus_val                = `CSR_MSTATUS_MPP;  // MPP fixed at 11
    mstatus_val[`CSR_BIT_MIE]  = status_mie;
    mstatus_val[`CSR_BIT_MPIE] = status_mpie;
  end

  ////////////////////////////////////////////////////////////
  // Interrupt enable and pending
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_r <= '0;
      meip  <= 1'b0;
      mtip  <= 1'b0;
      msip  <= 1'b0;
    end else begin
      if (wr_mie)
        mie_r <= dec.wdata & `CSR_MIE_MASK;  // Only MEIE, MTIE, MSIE stick
      meip <= irq.ext;  // One cycle behind the pins
      mtip <= irq.tmr;
      msip <= irq.sft;
    end
  end

  always_comb begin
    mip_val                = '0;
    mip_val[`CSR_BIT_MEIE] = meip;
    mip_val[`CSR_BIT_MTIE] = mtip;
    mip_val[`CSR_BIT_MSIE] = msip;
  end

  ////////////////////////////////////////////////////////////
  // Exception PC, cause, vector base and scratch
  assign epc_nxt = cmt.epc_ena ? cmt.epc : dec.wdata;  // Commit wins over write

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc_r     <= '0;
      mcause_r   <= '0;
      mtvec_r    <= `CSR_MTVEC_RESET;
      mscratch_r <= '0;
    end else begin
      if (cmt.epc_ena | wr_mepc)
        mepc_r <= {epc_nxt[`CSR_XLEN-1:1], 1'b0};  // Never odd
      if (cmt.cause_ena)
        mcause_r <= cmt.cause & `CSR_MCAUSE_MASK;
      else if (wr_mcause)
        mcause_r <= dec.wdata & `CSR_MCAUSE_MASK;
      if (wr_mtvec)
        mtvec_r <= dec.wdata;
      if (wr_mscratch)
        mscratch_r <= dec.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side of this bank
  always_comb begin
    bank_sel = 1'b1;
    rd_val   = '0;
    case (dec.sel)
      CSR_SEL_MSTATUS:  rd_val = mstatus_val;
      CSR_SEL_MIE:      rd_val = mie_r;
      CSR_SEL_MIP:      rd_val = mip_val;
      CSR_SEL_MEPC:     rd_val = mepc_r;
      CSR_SEL_MCAUSE:   rd_val = mcause_r;
      CSR_SEL_MTVEC:    rd_val = mtvec_r;
      CSR_SEL_MSCRATCH: rd_val = mscratch_r;
      default:          bank_sel = 1'b0;  // Not ours
    endcase
  end

  assign rd.hit  = dec.ren & bank_sel;
  assign rd.data = rd.hit ? rd_val : '0;

  // Control view for the core
  assign ctrl.status_mie = status_mie;
  assign ctrl.meie       = mie_r[`CSR_BIT_MEIE];
  assign ctrl.mtie       = mie_r[`CSR_BIT_MTIE];
  assign ctrl.msie       = mie_r[`CSR_BIT_MSIE];
  assign ctrl.mepc       = mepc_r;
  assign ctrl.mtvec      = mtvec_r;

endmodule

/* filelist.f */
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_trap_regs.sv
csr_counters.sv
csr_read_mux.sv
csr_file.sv
tb_csr_file.sv

/* tb_csr_file.sv */
// CSR file golden-record testbench
`timescale 1ns/100ps
`include "csr_consts.svh"

module tb_csr_file import csr_pkg::*; ();

  localparam int MAX_REC     = 64;   // Record slots in the golden array
  localparam int RST_CYCLES  = 16;
  localparam int RST_TIMEOUT = 100;  // Cycles allowed for reset release

  // Golden record operations
  typedef enum logic [3:0] {
    OP_IDLE    = 4'd0,
    OP_READ    = 4'd1,
    OP_WRITE   = 4'd2,
    OP_TRAP    = 4'd3,
    OP_MRET    = 4'd4,
    OP_INSTRET = 4'd5,
    OP_IRQ     = 4'd6
  } op_e;

  logic                 clk;
  logic                 rst_n;
  csr_req_t             req;
  csr_cmt_t             cmt;
  csr_irq_t             irq;
  logic [`CSR_XLEN-1:0] rdata;
  logic                 access_ilgl;
  csr_trap_ctrl_t       ctrl;
  logic                 tm_stop;

  logic [31:0] golden [0:4*MAX_REC-1];  // op, idx, data, expected per record
  int          n_rec;
  int          rd_errs;
  int          ctrl_errs;
  int          misc_errs;
  bit          released;

  csr_file u_csr_file (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .cmt         (cmt),
    .irq         (irq),
    .rdata       (rdata),
    .access_ilgl (access_ilgl),
    .ctrl        (ctrl),
    .tm_stop     (tm_stop)
  );

  ////////////////////////////////////////////////////////////
  // Clock and reset
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // Released on a falling edge
  end

  ////////////////////////////////////////////////////////////
  // Slots past the end of the golden file keep an Fxxx marker
  task automatic load_golden;
    for (int a = 0; a < 4*MAX_REC; a++)
      golden[a] = 32'hF000_0000 | 32'(a);
    $readmemh("csr_golden.txt", golden);
    n_rec = 0;
    while (n_rec < MAX_REC && golden[4*n_rec][31:28] != 4'hF)
      n_rec++;
  endtask

  task automatic wait_reset(output bit done);
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < RST_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    done = (rst_n === 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  task automatic check_read(input logic [`CSR_XLEN-1:0] exp_data, input logic exp_ilgl,
                            input int rec);
    if (rdata !== exp_data) begin
      rd_errs++;
      $display("ERR %0t: record %0d rdata %h, expected %h", $time, rec, rdata, exp_data);
    end
    if (access_ilgl !== exp_ilgl) begin
      rd_errs++;
      $display("ERR %0t: record %0d access_ilgl %b, expected %b",
               $time, rec, access_ilgl, exp_ilgl);
    end
  endtask

  task automatic check_ctrl(input csr_trap_ctrl_t exp_ctrl, input logic exp_stop,
                            input int rec);
    if (ctrl !== exp_ctrl) begin
      ctrl_errs++;
      $display("ERR %0t: record %0d ctrl mie/meie/mtie/msie %b%b%b%b mepc %h mtvec %h",
               $time, rec, ctrl.status_mie, ctrl.meie, ctrl.mtie, ctrl.msie,
               ctrl.mepc, ctrl.mtvec);
      $display("ERR %0t: record %0d expected %b%b%b%b mepc %h mtvec %h",
               $time, rec, exp_ctrl.status_mie, exp_ctrl.meie, exp_ctrl.mtie,
               exp_ctrl.msie, exp_ctrl.mepc, exp_ctrl.mtvec);
    end
    if (tm_stop !== exp_stop) begin
      ctrl_errs++;
      $display("ERR %0t: record %0d tm_stop %b, expected %b", $time, rec, tm_stop, exp_stop);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drive one record, then check it once outputs settle
  task automatic drive_record(input int rec);
    logic [31:0] op_w;
    logic [31:0] idx_w;
    logic [31:0] data_w;
    logic [31:0] exp_w;
    op_w   = golden[4*rec];
    idx_w  = golden[4*rec+1];
    data_w = golden[4*rec+2];
    exp_w  = golden[4*rec+3];
    req = '0;  // Strobes are single-cycle
    cmt = '0;
    case (op_e'(op_w[3:0]))
      OP_IDLE: ;
      OP_READ: begin
        req.ena = 1'b1;
        req.rd  = 1'b1;
        req.idx = idx_w[`CSR_IDX_W-1:0];
      end
      OP_WRITE: begin
        req.ena   = 1'b1;
        req.wr    = 1'b1;
        req.idx   = idx_w[`CSR_IDX_W-1:0];
        req.wdata = data_w;
      end
      OP_TRAP: begin
        cmt.trap      = 1'b1;
        cmt.epc_ena   = 1'b1;
        cmt.epc       = data_w;
        cmt.cause_ena = 1'b1;
        cmt.cause     = exp_w;
        if (idx_w != 0) begin  // Competing write carries the inverted epc
          req.ena   = 1'b1;
          req.wr    = 1'b1;
          req.idx   = idx_w[`CSR_IDX_W-1:0];
          req.wdata = ~data_w;
        end
      end
      OP_MRET:    cmt.mret    = 1'b1;
      OP_INSTRET: cmt.instret = 1'b1;
      OP_IRQ:     irq = csr_irq_t'(data_w[2:0]);  // Held until the next irq record
      default: begin
        misc_errs++;
        $display("Record %0d has an unknown operation code %h", rec, op_w);
      end
    endcase
  endtask

  task automatic check_record(input int rec);
    csr_trap_ctrl_t exp_ctrl;
    logic [31:0]    op_w;
    logic [31:0]    idx_w;
    op_w  = golden[4*rec];
    idx_w = golden[4*rec+1];
    if (op_w == 32'(OP_READ))
      check_read(golden[4*rec+3], golden[4*rec+2][0], rec);
    else if (op_w == 32'(OP_WRITE))
      check_read('0, golden[4*rec+3][0], rec);  // No read, so rdata stays zero
    else if (op_w == 32'(OP_IDLE) && idx_w[8]) begin
      exp_ctrl.status_mie = idx_w[4];
      exp_ctrl.meie       = idx_w[3];
      exp_ctrl.mtie       = idx_w[2];
      exp_ctrl.msie       = idx_w[1];
      exp_ctrl.mepc       = golden[4*rec+2];
      exp_ctrl.mtvec      = golden[4*rec+3];
      check_ctrl(exp_ctrl, idx_w[0], rec);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    req       = '0;
    cmt       = '0;
    irq       = '0;
    rd_errs   = 0;
    ctrl_errs = 0;
    misc_errs = 0;
    load_golden();
    if (n_rec == 0) begin
      misc_errs++;
      $display("No records could be loaded from csr_golden.txt");
    end
    wait_reset(released);
    if (!released) begin
      $display("Timeout: reset was not released within %0d cycles", RST_TIMEOUT);
      $display("sim failed");
      $finish;
    end else begin
      for (int r = 0; r < n_rec; r++) begin
        @(negedge clk);
        drive_record(r);
        #2;  // Mid low phase clear of both edges
        check_record(r);
      end
      @(negedge clk);
      req = '0;
      cmt = '0;
      $display("Error counts: read %0d, control %0d, other %0d",
               rd_errs, ctrl_errs, misc_errs);
      if (rd_errs + ctrl_errs + misc_errs == 0)
        $display("sim passed");
      else
        $display("sim failed");
      $finish;
    end
  end

endmodule
